// ==== filelist.f ====
source/bitman_pkg.sv
source/bitman_if.sv
source/bitman_in_stage.sv
source/bitman_popcnt.sv
source/bitman_ff1.sv
source/bitman_core.sv
source/bitman_out_stage.sv
source/bitman_top.sv
dv/bitman_tb.sv

// ==== Bender.yml ====
package:
  name: bitman

sources:
  - source/bitman_pkg.sv
  - source/bitman_if.sv
  - source/bitman_in_stage.sv
  - source/bitman_popcnt.sv
  - source/bitman_ff1.sv
  - source/bitman_core.sv
  - source/bitman_out_stage.sv
  - source/bitman_top.sv
  - target: test
    files:
      - dv/bitman_tb.sv

// ==== dv/bitman_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation unit testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_tb
  import bitman_pkg::*;
;

  // All tests together take about 500 cycles, so four times that is plenty
  localparam int max_cycles = 2000;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  op_e               op;
  logic [data_w-1:0] operand_a;
  logic [data_w-1:0] operand_b;
  logic              out_valid;
  logic [data_w-1:0] result;

  // Expected results in issue order and the in_valid history used for latency
  logic [data_w-1:0] exp_q [$];
  logic [data_w-1:0] exp_head;
  logic              vld_d1 = 1'b0;
  logic              vld_d2 = 1'b0;
  int                seed = 32'h72c1_70fd;
  int                cycles = 0;
  int                chk_pass = 0;
  int                chk_fail = 0;
  // Counter values when the current test started
  int                pass_mark;
  int                fail_mark;

  bitman_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .out_valid (out_valid),
    .result    (result)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [data_w-1:0] expected_result(op_e o, logic [31:0] a, logic [31:0] b);
    logic [31:0] w;
    int          off;
    int          len;
    int          n;
    bit          done;
    off = b[4:0];
    len = b[9:5];
    n = 0;
    done = 0;
    case (o)
      CNT:
      begin
        for (int i = 0; i < 32; i++)
        begin
          n += a[i];
        end
      end
      FF1:
      begin
        // Scanning down leaves the lowest set bit in n
        n = 32;
        for (int i = 31; i >= 0; i--)
        begin
          if (a[i])
            n = i;
        end
      end
      FL1:
      begin
        // Scanning up leaves the highest set bit in n
        n = 32;
        for (int i = 0; i < 32; i++)
        begin
          if (a[i])
            n = i;
        end
      end
      CLB:
      begin
        // Walk down from bit 30 while the bits still match the sign
        for (int i = 30; i >= 0; i--)
        begin
          if (!done && a[i] == a[31])
            n++;
          else
            done = 1;
        end
      end
      EXTRACTU:
      begin
        // Field bit i comes from bit off+i of a while that bit exists
        for (int i = 0; i < 32; i++)
        begin
          w[i] = (i <= len) && (i + off < 32) && a[i + off];
        end
        return w;
      end
      BSET:
      begin
        // Bit j lies in the field when it sits from off up to off+len
        for (int j = 0; j < 32; j++)
        begin
          w[j] = a[j] | ((j >= off) && (j - off <= len));
        end
        return w;
      end
      default:
      begin
        for (int j = 0; j < 32; j++)
        begin
          w[j] = a[j] & !((j >= off) && (j - off <= len));
        end
        return w;
      end
    endcase
    return n;
  endfunction

  // Operand b holding an offset and a length-minus-one
  function automatic logic [31:0] field_spec(int off, int len_m1);
    return ((len_m1 & 31) << 5) | (off & 31);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks run at the falling edge where outputs are stable
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    // Every in_valid has to come back as out_valid two cycles later
    assert (out_valid === vld_d2)
      chk_pass++;
    else
    begin
      chk_fail++;
      $display("ERR out_valid: expected 0x%0h, got 0x%0h at %0t", vld_d2, out_valid, $time);
    end
    if (out_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        chk_fail++;
        $display("Result arrived at %0t with no operation outstanding", $time);
      end
      else
      begin
        // Results leave in issue order
        exp_head = exp_q.pop_front();
        assert (result === exp_head)
          chk_pass++;
        else
        begin
          chk_fail++;
          $display("ERR result: expected 0x%08h, got 0x%08h", exp_head, result);
        end
      end
    end
    vld_d2 = vld_d1;
    vld_d1 = in_valid;
  end

  // Hard stop in case something never drains
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // One operation held for one cycle with inputs changing 1 ns after the edge
  task automatic issue_op(op_e o, logic [31:0] a, logic [31:0] b);
    in_valid  = 1'b1;
    op        = o;
    operand_a = a;
    operand_b = b;
    exp_q.push_back(expected_result(o, a, b));
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic idle_cycles(int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Waits until every outstanding result has been compared
  task automatic drain_results();
    while (exp_q.size() != 0)
      idle_cycles(1);
    idle_cycles(2);
  endtask

  task automatic open_test();
    pass_mark = chk_pass;
    fail_mark = chk_fail;
  endtask

  task automatic close_test(string name);
    drain_results();
    $display("%-12s done: %0d checks passed, %0d failed", name,
             chk_pass - pass_mark, chk_fail - fail_mark);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    op_e ops [3];
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op        = CNT;
    operand_a = '0;
    operand_b = '0;
    ops[0] = FF1;
    ops[1] = FL1;
    ops[2] = CLB;

    // out_valid must stay low through reset and the idle cycles after it
    open_test();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(5);
    close_test("reset");

    open_test();
    issue_op(CNT, 32'h0, 32'h0);
    issue_op(CNT, 32'hffff_ffff, 32'h0);
    for (int i = 0; i < 32; i++)
      issue_op(CNT, 32'h1 << i, 32'h0);
    for (int i = 0; i < 100; i++)
      issue_op(CNT, $random(seed), 32'h0);
    close_test("cnt");

    // Zero, all ones, walking ones, negatives and random words per opcode
    open_test();
    foreach (ops[k])
    begin
      issue_op(ops[k], 32'h0, 32'h0);
      issue_op(ops[k], 32'hffff_ffff, 32'h0);
      for (int i = 0; i < 32; i++)
        issue_op(ops[k], 32'h1 << i, 32'h0);
      issue_op(ops[k], 32'h8000_0000, 32'h0);
      issue_op(ops[k], 32'hffff_fff0, 32'h0);
      issue_op(ops[k], 32'hc000_1234, 32'h0);
      for (int i = 0; i < 15; i++)
        issue_op(ops[k], $random(seed), 32'h0);
    end
    close_test("ff1_fl1_clb");

    // Fixed corners push the field past bit 31 and the rest is random
    open_test();
    for (int k = EXTRACTU; k <= BCLR; k++)
    begin
      issue_op(op_e'(k), 32'hdead_beef, field_spec(28, 7));
      issue_op(op_e'(k), 32'h1234_5678, field_spec(31, 31));
      issue_op(op_e'(k), 32'h8765_4321, field_spec(0, 31));
      issue_op(op_e'(k), 32'h0f0f_0f0f, field_spec(16, 0));
      for (int i = 0; i < 30; i++)
        issue_op(op_e'(k), $random(seed), $random(seed));
    end
    close_test("bit_field");

    // Mixed opcodes on consecutive cycles with the odd gap
    open_test();
    for (int i = 0; i < 60; i++)
    begin
      issue_op(op_e'(($random(seed) & 32'h7fff_ffff) % 7), $random(seed), $random(seed));
      if (($random(seed) & 3) == 0)
        idle_cycles(1);
    end
    close_test("throughput");

    $display("Checks passed: %0d, checks failed: %0d", chk_pass, chk_fail);
    if (chk_fail == 0 && exp_q.size() == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== source/bitman_top.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_top
  import bitman_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  op_e               op,
  input  logic [data_w-1:0] operand_a,
  input  logic [data_w-1:0] operand_b,
  output logic              out_valid,
  output logic [data_w-1:0] result
);

  // Registered operation and the core's partial results
  bitman_op_if  op_bus ();
  bitman_res_if res_bus ();

  // Cycle one registers the operation and decodes the field
  bitman_in_stage u_in_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op_bus    (op_bus.producer)
  );

  bitman_core u_core (
    .op_bus  (op_bus.consumer),
    .res_bus (res_bus.producer)
  );

  // Cycle two selects and registers the answer
  bitman_out_stage u_out_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_bus   (res_bus.consumer),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

// ==== source/bitman_out_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Output register stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_out_stage
  import bitman_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  bitman_res_if.consumer    res_bus,
  output logic              out_valid,
  output logic [data_w-1:0] result
);

  logic [data_w-1:0] result_sel;

  // Pick the partial result that belongs to the opcode
  always_comb
  begin
    case (res_bus.op)
      CNT:           result_sel = {{(data_w-idx_w){1'b0}}, res_bus.cnt};
      FF1, FL1, CLB: result_sel = {{(data_w-idx_w){1'b0}}, res_bus.bit_idx};
      default:       result_sel = res_bus.field_res;
    endcase
  end

  // Output strobe, cleared on reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= res_bus.valid;
    end
  end

  // The result word only moves when a new operation arrives
  always_ff @(posedge clk)
  begin
    if (res_bus.valid)
    begin
      result <= result_sel;
    end
  end

endmodule

// ==== source/bitman_core.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation datapath
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_core
  import bitman_pkg::*;
(
  bitman_op_if.consumer  op_bus,
  bitman_res_if.producer res_bus
);

  // Word handed to the find-first-one tree
  logic [data_w-1:0] ff1_in;
  logic [idx_w-1:0]  first_one;
  logic              no_ones;
  // Operand a reversed, and the sign-compare word for CLB
  logic [data_w-1:0] a_rev;
  logic [data_w-1:0] a_clb;
  // Field mask moved up to its place in the word
  logic [data_w-1:0] field_at_off;

  //////////////////////////////////////////////////////////////////////
  // Counting trees
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < data_w; i++)
    begin
      a_rev[i] = op_bus.operand_a[data_w-1-i];
    end

    // Bit i tells whether bit 30-i differs from the sign bit
    // Bit 31 is forced so a word with all bits equal still stops at 31
    for (int i = 0; i < data_w - 1; i++)
    begin
      a_clb[i] = op_bus.operand_a[data_w-2-i] ^ op_bus.operand_a[data_w-1];
    end
    a_clb[data_w-1] = 1'b1;
  end

  // FL1 and CLB need the tree to scan from the top, so they get a
  // mirrored word; everything else sees operand a as it is
  always_comb
  begin
    case (op_bus.op)
      FL1:     ff1_in = a_rev;
      CLB:     ff1_in = a_clb;
      default: ff1_in = op_bus.operand_a;
    endcase
  end

  bitman_popcnt u_popcnt (
    .in     (op_bus.operand_a),
    .result (res_bus.cnt)
  );

  bitman_ff1 u_ff1 (
    .in        (ff1_in),
    .first_one (first_one),
    .no_ones   (no_ones)
  );

  // Index found in the mirrored word is converted back for FL1
  always_comb
  begin
    if (op_bus.op == FL1 && !no_ones)
    begin
      res_bus.bit_idx = 6'd31 - first_one;
    end
    else
    begin
      res_bus.bit_idx = first_one;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bit fields
  //////////////////////////////////////////////////////////////////////

  // Bits pushed beyond bit 31 simply fall off
  assign field_at_off = op_bus.field_mask << op_bus.field_off;

  always_comb
  begin
    case (op_bus.op)
      BSET:    res_bus.field_res = op_bus.operand_a | field_at_off;
      BCLR:    res_bus.field_res = op_bus.operand_a & ~field_at_off;
      default: res_bus.field_res = (op_bus.operand_a >> op_bus.field_off)
                                   & op_bus.field_mask;
    endcase
  end

  // Strobe and opcode ride along to the output stage
  assign res_bus.valid = op_bus.valid;
  assign res_bus.op    = op_bus.op;

endmodule

// ==== source/bitman_ff1.sv ====
//////////////////////////////////////////////////////////////////////
// Find first one
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_ff1
  import bitman_pkg::*;
(
  input  logic [data_w-1:0] in,
  output logic [idx_w-1:0]  first_one,
  output logic              no_ones
);

  // Tree nodes stored heap style, node 0 is the root
  // Level lv holds nodes 2**lv-1 up to 2**(lv+1)-2
  // Node k has its lower child at 2k+1 and its upper child at 2k+2
  logic [30:0] has_one;
  // A node at level lv only uses the low 5-lv bits, the rest stay zero
  logic [4:0]  pos [31];

  for (genvar lv = 0; lv < 5; lv++)
  begin : g_level
    for (genvar p = 0; p < (1 << lv); p++)
    begin : g_node
      localparam int k = (1 << lv) - 1 + p;

      if (lv == 4)
      begin : g_leaf
        // Bottom nodes look straight at a pair of input bits
        assign has_one[k] = in[2*p] | in[2*p+1];
        assign pos[k]     = {4'b0000, ~in[2*p]};
      end
      else
      begin : g_inner
        assign has_one[k] = has_one[2*k+1] | has_one[2*k+2];
        // Prefer the lower half; the upper half sets the node's leading bit
        assign pos[k] = has_one[2*k+1] ? pos[2*k+1]
                                       : (pos[2*k+2] | (5'd1 << (4 - lv)));
      end
    end
  end

  // Root has no one when the whole word is zero
  assign no_ones   = ~has_one[0];
  // Reported index is 32 in that case
  assign first_one = no_ones ? 6'd32 : {1'b0, pos[0]};

endmodule

// ==== source/bitman_popcnt.sv ====
//////////////////////////////////////////////////////////////////////
// Population count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_popcnt
  import bitman_pkg::*;
(
  input  logic [data_w-1:0] in,
  output logic [idx_w-1:0]  result
);

  // Partial sums, each level one bit wider than the one below
  logic [15:0][1:0] sum_l1;
  logic [ 7:0][2:0] sum_l2;
  logic [ 3:0][3:0] sum_l3;
  logic [ 1:0][4:0] sum_l4;

  // Pairwise adder tree over five levels
  always_comb
  begin
    // Level one adds neighbouring input bits
    for (int i = 0; i < 16; i++)
    begin
      sum_l1[i] = {1'b0, in[2*i]} + {1'b0, in[2*i+1]};
    end

    for (int i = 0; i < 8; i++)
    begin
      sum_l2[i] = {1'b0, sum_l1[2*i]} + {1'b0, sum_l1[2*i+1]};
    end

    for (int i = 0; i < 4; i++)
    begin
      sum_l3[i] = {1'b0, sum_l2[2*i]} + {1'b0, sum_l2[2*i+1]};
    end

    for (int i = 0; i < 2; i++)
    begin
      sum_l4[i] = {1'b0, sum_l3[2*i]} + {1'b0, sum_l3[2*i+1]};
    end
  end

  // Last level, the full count of up to 32 ones
  assign result = {1'b0, sum_l4[0]} + {1'b0, sum_l4[1]};

endmodule

// ==== source/bitman_in_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Input register stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bitman_in_stage
  import bitman_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  op_e               op,
  input  logic [data_w-1:0] operand_a,
  input  logic [data_w-1:0] operand_b,
  bitman_op_if.producer     op_bus
);

  // Field spec pulled out of operand b
  logic [fld_w-1:0]  len_m1;
  logic [fld_w-1:0]  offset;
  logic [data_w-1:0] mask;

  //////////////////////////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////////////////////////

  assign offset = operand_b[off_lsb +: fld_w];
  assign len_m1 = operand_b[len_lsb +: fld_w];

  // Thermometer code with len+1 ones at the bottom
  // A zero is pushed in at bit 0 and shifted up by the length, so after
  // inversion exactly the bits 0 to len stay set
  // For len 31 the shift clears the word and the mask becomes all ones
  assign mask = ~({{(data_w-1){1'b1}}, 1'b0} << len_m1);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  // Only the strobe carries state across reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      op_bus.valid <= 1'b0;
    end
    else
    begin
      op_bus.valid <= in_valid;
    end
  end

  // Payload is loaded with every accepted operation
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      op_bus.op         <= op;
      op_bus.operand_a  <= operand_a;
      op_bus.field_off  <= offset;
      op_bus.field_mask <= mask;
    end
  end

endmodule

// ==== source/bitman_if.sv ====
//////////////////////////////////////////////////////////////////////
// Internal buses of the bit-manipulation unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

// Registered operation handed from the input stage to the core
interface bitman_op_if
  import bitman_pkg::*;
();

  logic                valid;
  op_e                 op;
  logic [data_w-1:0]   operand_a;
  // Start bit of the bit field
  logic [fld_w-1:0]    field_off;
  // The lowest len+1 bits are set, the rest are clear
  logic [data_w-1:0]   field_mask;

  modport producer (output valid, op, operand_a, field_off, field_mask);
  modport consumer (input valid, op, operand_a, field_off, field_mask);

endinterface

// Partial results of the core, one per operation class
interface bitman_res_if
  import bitman_pkg::*;
();

  logic                valid;
  op_e                 op;
  // Ones count of operand a
  logic [idx_w-1:0]    cnt;
  // Answer for FF1, FL1 and CLB
  logic [idx_w-1:0]    bit_idx;
  // Extracted, set or cleared word
  logic [data_w-1:0]   field_res;

  modport producer (output valid, op, cnt, bit_idx, field_res);
  modport consumer (input valid, op, cnt, bit_idx, field_res);

endinterface

// ==== source/bitman_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Bit-manipulation unit definitions
//////////////////////////////////////////////////////////////////////

package bitman_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Operand and result width of the whole unit
  localparam int data_w = 32;

  // A bit index or a ones count needs one bit more than five
  // Values 0 to 32 must fit
  localparam int idx_w = 6;

  // Width of the offset and of the length-minus-one fields
  localparam int fld_w = 5;

  //////////////////////////////////////////////////////////////////////
  // Operand b bit-field layout
  //////////////////////////////////////////////////////////////////////

  // Offset of the field inside the word sits in the low five bits
  localparam int off_lsb = 0;

  // Field length minus one sits right above the offset
  localparam int len_lsb = 5;

  //////////////////////////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////////////////////////

  // The first four use the counting trees, the rest the bit-field path
  typedef enum logic [2:0] {
    CNT      = 3'd0,
    FF1      = 3'd1,
    FL1      = 3'd2,
    CLB      = 3'd3,
    EXTRACTU = 3'd4,
    BSET     = 3'd5,
    BCLR     = 3'd6
  } op_e;

endpackage
